// File: flist.f
hdl/nocPkg.sv
hdl/linkReceiver.sv
hdl/grantCounter.sv
hdl/outputArbiter.sv
hdl/linkSender.sv
hdl/routerOutputPort.sv
verification/routerOutputPortTb.sv

// File: hdl/grantCounter.sv
`default_nettype none

module grantCounter
  import nocPkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             loadLen,
  input  logic [LEN_W-1:0] lenIn,
  input  logic             runCount,
  output logic             done
);

  logic [LEN_W-1:0] lenReg;
  logic [LEN_W-1:0] count;

  // Count survives a lost grant, so a packet cut short resumes where it stopped
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lenReg <= '0;
      count  <= '0;
    end
    else if (loadLen)
    begin
      lenReg <= lenIn;
      // Header pop is the first flit of the new packet
      count  <= runCount ? LEN_W'(1) : '0;
    end
    else if (runCount)
    begin
      count <= count + 1'b1;
    end
  end

  assign done = count == lenReg;

  // Arbiter must stop popping once the packet is complete
  noPopPastEnd: assert property (@(posedge clk) disable iff (rst)
    runCount && !loadLen |-> !done);

endmodule

`default_nettype wire

// File: hdl/linkReceiver.sv
`default_nettype none

module linkReceiver
  import nocPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 inReq,
  output logic                 inAck,
  input  flitKind_t            inKind,
  input  logic [PAYLOAD_W-1:0] inData,
  input  logic                 pop,
  output logic                 fifoValid,
  output flitKind_t            fifoKind,
  output logic [PAYLOAD_W-1:0] fifoData
);

  flitKind_t            kindMem [FIFO_DEPTH];
  logic [PAYLOAD_W-1:0] dataMem [FIFO_DEPTH];
  logic [FIFO_AW-1:0]   wrPtr;
  logic [FIFO_AW-1:0]   rdPtr;
  logic [FIFO_AW:0]     used;
  logic                 full;
  logic                 write;

  assign full = used == (FIFO_AW+1)'(FIFO_DEPTH);

  // A request is taken only while ack is low, so each flit lands once
  assign write = inReq && !inAck && !full;

  // Ack doubles as the accepted flag of the current request
  always_ff @(posedge clk)
  begin
    if (rst)
      inAck <= 1'b0;
    else if (write)
      inAck <= 1'b1;
    else if (inAck && !inReq)
      inAck <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      used  <= '0;
    end
    else
    begin
      if (write)
        wrPtr <= wrPtr + 1'b1;
      if (pop)
        rdPtr <= rdPtr + 1'b1;
      if (write && !pop)
        used <= used + 1'b1;
      else if (pop && !write)
        used <= used - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (write)
    begin
      kindMem[wrPtr] <= inKind;
      dataMem[wrPtr] <= inData;
    end
  end

  // Head of queue is always visible to the arbiter
  assign fifoValid = used != '0;
  assign fifoKind  = kindMem[rdPtr];
  assign fifoData  = dataMem[rdPtr];

  popNeedsFlit: assert property (@(posedge clk) disable iff (rst)
    pop |-> fifoValid);

endmodule

`default_nettype wire

// File: hdl/linkSender.sv
`default_nettype none

module linkSender
  import nocPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 sendValid,
  input  flitKind_t            sendKind,
  input  logic [PAYLOAD_W-1:0] sendData,
  output logic                 sendReady,
  output logic                 outReq,
  input  logic                 outAck,
  output flitKind_t            outKind,
  output logic [PAYLOAD_W-1:0] outData
);

  typedef enum logic [1:0] {
    EMPTY,
    REQUESTING,
    WAIT_DROP
  } senderState_t;

  senderState_t state;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state  <= EMPTY;
      outReq <= 1'b0;
    end
    else
    begin
      case (state)
        EMPTY:
        begin
          if (sendValid)
            state <= REQUESTING;
        end
        REQUESTING:
        begin
          // Req rises the cycle after the flit is latched
          if (outReq && outAck)
          begin
            outReq <= 1'b0;
            state  <= WAIT_DROP;
          end
          else
          begin
            outReq <= 1'b1;
          end
        end
        WAIT_DROP:
        begin
          if (!outAck)
            state <= EMPTY;
        end
        default:
          state <= EMPTY;
      endcase
    end
  end

  // Flit held until the return-to-zero phase ends
  always_ff @(posedge clk)
  begin
    if (sendValid && state == EMPTY)
    begin
      outKind <= sendKind;
      outData <= sendData;
    end
  end

  assign sendReady = state == EMPTY;

  dataStableWhileReq: assert property (@(posedge clk) disable iff (rst)
    outReq && $past(outReq) |-> $stable(outData));

endmodule

`default_nettype wire

// File: hdl/nocPkg.sv
`default_nettype none

package nocPkg;

  // One-hot flit kind, the header is tested on its own bit pattern
  typedef enum logic [2:0] {
    KIND_HEAD = 3'b001,
    KIND_BODY = 3'b010,
    KIND_TAIL = 3'b100
  } flitKind_t;

  // Arbiter states, one per input port plus idle
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    LOCAL = 3'd1,
    NORTH = 3'd2,
    EAST  = 3'd3,
    WEST  = 3'd4,
    SOUTH = 3'd5
  } portSel_t;

  // Port index is state minus one, L N E W S
  localparam int NUM_PORTS = 5;

  localparam int PAYLOAD_W = 16;

  // Header payload layout
  // Length counts every flit of the packet, header and tail included
  localparam int LEN_W   = 12;
  localparam int SRC_LSB = 12;

  // Input FIFO, depth is a power of two so pointers wrap on their own
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW    = 2;

endpackage

`default_nettype wire

// File: hdl/outputArbiter.sv
`default_nettype none

module outputArbiter
  import nocPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [NUM_PORTS-1:0] fifoValid,
  input  flitKind_t            fifoKindL,
  input  flitKind_t            fifoKindN,
  input  flitKind_t            fifoKindE,
  input  flitKind_t            fifoKindW,
  input  flitKind_t            fifoKindS,
  input  logic [PAYLOAD_W-1:0] fifoDataL,
  input  logic [PAYLOAD_W-1:0] fifoDataN,
  input  logic [PAYLOAD_W-1:0] fifoDataE,
  input  logic [PAYLOAD_W-1:0] fifoDataW,
  input  logic [PAYLOAD_W-1:0] fifoDataS,
  input  logic                 sendReady,
  output logic [NUM_PORTS-1:0] pop,
  output logic [NUM_PORTS-1:0] runCount,
  output logic [NUM_PORTS-1:0] loadLen,
  input  logic [NUM_PORTS-1:0] done,
  output logic                 sendValid,
  output flitKind_t            sendKind,
  output logic [PAYLOAD_W-1:0] sendData
);

  portSel_t             state;
  portSel_t             nextState;
  logic                 granted;
  logic [2:0]           curIdx;
  logic                 grantUsed;
  logic                 keep;
  flitKind_t            kindArr [NUM_PORTS];
  logic [PAYLOAD_W-1:0] dataArr [NUM_PORTS];

  function automatic portSel_t portOf(input int idx);
    return portSel_t'(3'(idx + 1));
  endfunction

  assign kindArr[0] = fifoKindL;
  assign kindArr[1] = fifoKindN;
  assign kindArr[2] = fifoKindE;
  assign kindArr[3] = fifoKindW;
  assign kindArr[4] = fifoKindS;
  assign dataArr[0] = fifoDataL;
  assign dataArr[1] = fifoDataN;
  assign dataArr[2] = fifoDataE;
  assign dataArr[3] = fifoDataW;
  assign dataArr[4] = fifoDataS;

  assign granted = state != IDLE;
  assign curIdx  = granted ? 3'(state) - 3'd1 : 3'd0;

  // A stale done from the last packet only counts once this grant has popped
  assign keep = granted && fifoValid[curIdx] && !(done[curIdx] && grantUsed);

  always_comb
  begin
    int idx;
    idx       = 0;
    nextState = state;
    if (!granted)
    begin
      // Fixed priority from idle with L highest
      for (int k = NUM_PORTS - 1; k >= 0; k--)
      begin
        if (fifoValid[k])
          nextState = portOf(k);
      end
    end
    else if (!keep)
    begin
      nextState = IDLE;
      // Walked backwards so the nearest successor in rotation wins
      for (int k = NUM_PORTS - 1; k >= 1; k--)
      begin
        idx = (int'(curIdx) + k) % NUM_PORTS;
        if (fifoValid[idx])
          nextState = portOf(idx);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= IDLE;
      grantUsed <= 1'b0;
    end
    else
    begin
      state <= nextState;
      if (nextState != state)
        grantUsed <= 1'b0;
      else if (|pop)
        grantUsed <= 1'b1;
    end
  end

  always_comb
  begin
    pop = '0;
    if (keep && sendReady)
      pop[curIdx] = 1'b1;
  end

  always_comb
  begin
    for (int k = 0; k < NUM_PORTS; k++)
      loadLen[k] = pop[k] && kindArr[k] == KIND_HEAD;
  end

  assign runCount  = pop;
  assign sendValid = |pop;
  assign sendKind  = kindArr[curIdx];
  assign sendData  = dataArr[curIdx];

  // The tail pop brings the port counter up to the header length
  tailCompletesPacket: assert property (@(posedge clk) disable iff (rst)
    sendValid && sendKind == KIND_TAIL |=> |(done & $past(pop)));

  // A packet holds at least a header and a tail
  headerLenAtLeastTwo: assert property (@(posedge clk) disable iff (rst)
    |loadLen |-> sendData[LEN_W-1:0] >= LEN_W'(2));

endmodule

`default_nettype wire

// File: hdl/routerOutputPort.sv
`default_nettype none

module routerOutputPort
  import nocPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 inReqL,
  input  logic                 inReqN,
  input  logic                 inReqE,
  input  logic                 inReqW,
  input  logic                 inReqS,
  output logic                 inAckL,
  output logic                 inAckN,
  output logic                 inAckE,
  output logic                 inAckW,
  output logic                 inAckS,
  input  flitKind_t            inKindL,
  input  flitKind_t            inKindN,
  input  flitKind_t            inKindE,
  input  flitKind_t            inKindW,
  input  flitKind_t            inKindS,
  input  logic [PAYLOAD_W-1:0] inDataL,
  input  logic [PAYLOAD_W-1:0] inDataN,
  input  logic [PAYLOAD_W-1:0] inDataE,
  input  logic [PAYLOAD_W-1:0] inDataW,
  input  logic [PAYLOAD_W-1:0] inDataS,
  output logic                 outReq,
  input  logic                 outAck,
  output flitKind_t            outKind,
  output logic [PAYLOAD_W-1:0] outData
);

  // Bit index per port is L 0, N 1, E 2, W 3, S 4
  logic [NUM_PORTS-1:0] fifoValid;
  logic [NUM_PORTS-1:0] pop;
  logic [NUM_PORTS-1:0] runCount;
  logic [NUM_PORTS-1:0] loadLen;
  logic [NUM_PORTS-1:0] done;
  flitKind_t            fifoKindL;
  flitKind_t            fifoKindN;
  flitKind_t            fifoKindE;
  flitKind_t            fifoKindW;
  flitKind_t            fifoKindS;
  logic [PAYLOAD_W-1:0] fifoDataL;
  logic [PAYLOAD_W-1:0] fifoDataN;
  logic [PAYLOAD_W-1:0] fifoDataE;
  logic [PAYLOAD_W-1:0] fifoDataW;
  logic [PAYLOAD_W-1:0] fifoDataS;
  logic                 sendValid;
  logic                 sendReady;
  flitKind_t            sendKind;
  logic [PAYLOAD_W-1:0] sendData;

  linkReceiver rxLocal (
    .clk(clk), .rst(rst),
    .inReq(inReqL), .inAck(inAckL), .inKind(inKindL), .inData(inDataL),
    .pop(pop[0]), .fifoValid(fifoValid[0]), .fifoKind(fifoKindL), .fifoData(fifoDataL)
  );
  linkReceiver rxNorth (
    .clk(clk), .rst(rst),
    .inReq(inReqN), .inAck(inAckN), .inKind(inKindN), .inData(inDataN),
    .pop(pop[1]), .fifoValid(fifoValid[1]), .fifoKind(fifoKindN), .fifoData(fifoDataN)
  );
  linkReceiver rxEast (
    .clk(clk), .rst(rst),
    .inReq(inReqE), .inAck(inAckE), .inKind(inKindE), .inData(inDataE),
    .pop(pop[2]), .fifoValid(fifoValid[2]), .fifoKind(fifoKindE), .fifoData(fifoDataE)
  );
  linkReceiver rxWest (
    .clk(clk), .rst(rst),
    .inReq(inReqW), .inAck(inAckW), .inKind(inKindW), .inData(inDataW),
    .pop(pop[3]), .fifoValid(fifoValid[3]), .fifoKind(fifoKindW), .fifoData(fifoDataW)
  );
  linkReceiver rxSouth (
    .clk(clk), .rst(rst),
    .inReq(inReqS), .inAck(inAckS), .inKind(inKindS), .inData(inDataS),
    .pop(pop[4]), .fifoValid(fifoValid[4]), .fifoKind(fifoKindS), .fifoData(fifoDataS)
  );

  // Length field is read straight off the FIFO head when the header pops
  grantCounter cntLocal (
    .clk(clk), .rst(rst), .loadLen(loadLen[0]), .lenIn(fifoDataL[LEN_W-1:0]),
    .runCount(runCount[0]), .done(done[0])
  );
  grantCounter cntNorth (
    .clk(clk), .rst(rst), .loadLen(loadLen[1]), .lenIn(fifoDataN[LEN_W-1:0]),
    .runCount(runCount[1]), .done(done[1])
  );
  grantCounter cntEast (
    .clk(clk), .rst(rst), .loadLen(loadLen[2]), .lenIn(fifoDataE[LEN_W-1:0]),
    .runCount(runCount[2]), .done(done[2])
  );
  grantCounter cntWest (
    .clk(clk), .rst(rst), .loadLen(loadLen[3]), .lenIn(fifoDataW[LEN_W-1:0]),
    .runCount(runCount[3]), .done(done[3])
  );
  grantCounter cntSouth (
    .clk(clk), .rst(rst), .loadLen(loadLen[4]), .lenIn(fifoDataS[LEN_W-1:0]),
    .runCount(runCount[4]), .done(done[4])
  );

  outputArbiter arb (
    .clk(clk), .rst(rst), .fifoValid(fifoValid),
    .fifoKindL(fifoKindL), .fifoKindN(fifoKindN), .fifoKindE(fifoKindE),
    .fifoKindW(fifoKindW), .fifoKindS(fifoKindS),
    .fifoDataL(fifoDataL), .fifoDataN(fifoDataN), .fifoDataE(fifoDataE),
    .fifoDataW(fifoDataW), .fifoDataS(fifoDataS),
    .sendReady(sendReady), .pop(pop), .runCount(runCount), .loadLen(loadLen),
    .done(done), .sendValid(sendValid), .sendKind(sendKind), .sendData(sendData)
  );

  linkSender tx (
    .clk(clk), .rst(rst),
    .sendValid(sendValid), .sendKind(sendKind), .sendData(sendData), .sendReady(sendReady),
    .outReq(outReq), .outAck(outAck), .outKind(outKind), .outData(outData)
  );

endmodule

`default_nettype wire

// File: verification/routerCases.txt
# test port(0 L, 1 N, 2 E, 3 W, 4 S) length start-delay hold
# hold 1 keeps outAck low until every packet of the test is loaded
1 0 4 0 0
2 1 3 0 0
3 2 6 2 0
4 3 2 0 0
5 4 5 1 0
6 0 5 3 0
6 1 7 0 0
6 3 4 5 0
6 4 6 1 0
7 0 3 0 1
7 1 4 0 1
7 2 2 0 1
7 3 4 0 1
7 4 3 0 1
8 0 2 0 1
8 1 2 0 1
8 2 4 0 1
8 3 3 0 1
8 4 4 0 1
9 0 12 0 0
9 2 10 0 0
9 4 9 2 0
9 1 11 4 0

// File: verification/routerOutputPortTb.sv
`default_nettype none

module routerOutputPortTb
  import nocPkg::*;
();

  localparam string CASES_FILE = "verification/routerCases.txt";
  localparam int    EXP_SLOTS  = 128;

  logic                 clk;
  logic                 rst;
  logic [4:0]           inReq;
  wire  [4:0]           inAck;
  flitKind_t            inKind [NUM_PORTS];
  logic [PAYLOAD_W-1:0] inData [NUM_PORTS];
  logic                 outReq;
  logic                 outAck;
  flitKind_t            outKind;
  logic [PAYLOAD_W-1:0] outData;

  int caseTest[$];
  int casePort[$];
  int caseLen[$];
  int caseDelay[$];
  int caseHold[$];

  // Expected flits per input port as {kind, payload}
  logic [PAYLOAD_W+2:0] expMem [NUM_PORTS][EXP_SLOTS];
  int                   expWr [NUM_PORTS];
  int                   expRd [NUM_PORTS];
  int                   sentFlits [NUM_PORTS];
  int                   ackRises [NUM_PORTS];
  logic [4:0]           ackSeen;
  int                   orderList [NUM_PORTS];
  int                   orderLen;
  int                   orderPos;
  logic [15:0]          lfsr;
  logic                 holdTest;
  logic                 holdAck;
  logic                 inPacket;
  int                   curSrc;
  int                   pktsDone;
  int                   errors;
  int                   testsPassed;
  int                   testsFailed;
  int                   limitCycles;
  logic                 casesLoaded;

  routerOutputPort i_dut (
    .clk(clk), .rst(rst),
    .inReqL(inReq[0]), .inAckL(inAck[0]), .inKindL(inKind[0]), .inDataL(inData[0]),
    .inReqN(inReq[1]), .inAckN(inAck[1]), .inKindN(inKind[1]), .inDataN(inData[1]),
    .inReqE(inReq[2]), .inAckE(inAck[2]), .inKindE(inKind[2]), .inDataE(inData[2]),
    .inReqW(inReq[3]), .inAckW(inAck[3]), .inKindW(inKind[3]), .inDataW(inData[3]),
    .inReqS(inReq[4]), .inAckS(inAck[4]), .inKindS(inKind[4]), .inDataS(inData[4]),
    .outReq(outReq), .outAck(outAck), .outKind(outKind), .outData(outData)
  );

  always #2 clk = ~clk;

  // Galois LFSR stepped once for every bit handed out
  function automatic logic [15:0] takeBits(input int n);
    logic [15:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      bits = {bits[14:0], lfsr[0]};
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1;
    end
    return bits;
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] observed);
    $display("FAIL %s expected %h observed %h", name, expected, observed);
    errors++;
  endtask

  task automatic reportProblem(input string msg);
    $display("ERROR: %s", msg);
    errors++;
  endtask

  // Four-phase sender on one input link that queues each flit as expected before driving it
  task automatic sendPacket(input int p, input int len, input int startDelay);
    flitKind_t            kind;
    logic [PAYLOAD_W-1:0] data;
    repeat (startDelay) @(posedge clk);
    @(posedge clk);
    #1;
    for (int i = 0; i < len; i++)
    begin
      kind = (i == 0) ? KIND_HEAD : (i == len - 1) ? KIND_TAIL : KIND_BODY;
      data = (i == 0) ? (PAYLOAD_W'(p) << SRC_LSB) | PAYLOAD_W'(len) : takeBits(PAYLOAD_W);
      expMem[p][expWr[p] % EXP_SLOTS] = {kind, data};
      expWr[p]++;
      inKind[p] = kind;
      inData[p] = data;
      inReq[p]  = 1'b1;
      do
      begin
        @(posedge clk);
        #1;
      end
      while (!inAck[p]);
      inReq[p] = 1'b0;
      sentFlits[p]++;
      do
      begin
        @(posedge clk);
        #1;
      end
      while (inAck[p]);
    end
  endtask

  // The header source field picks which port queue the following flits come from
  task automatic checkFlit(input flitKind_t kind, input logic [PAYLOAD_W-1:0] data);
    logic [PAYLOAD_W+2:0] expected;
    int                   src;
    if (kind == KIND_HEAD)
    begin
      src = int'(data[SRC_LSB+2:SRC_LSB]);
      assert (!inPacket)
      else reportProblem($sformatf("header from port %0d interleaved an open packet", src));
      if (holdTest && orderPos < orderLen)
      begin
        assert (src == orderList[orderPos])
        else reportMismatch("outData source field", orderList[orderPos], src);
        orderPos++;
      end
      inPacket = 1'b1;
      curSrc   = (src < NUM_PORTS) ? src : -1;
    end
    else
    begin
      assert (inPacket) else reportProblem("body or tail flit arrived with no open packet");
    end
    if (curSrc < 0 || expRd[curSrc] == expWr[curSrc])
    begin
      reportProblem($sformatf("output flit %h kind %h matches no sent flit", data, kind));
    end
    else
    begin
      expected = expMem[curSrc][expRd[curSrc] % EXP_SLOTS];
      expRd[curSrc]++;
      assert (kind == expected[PAYLOAD_W+2:PAYLOAD_W])
      else reportMismatch("outKind", expected[PAYLOAD_W+2:PAYLOAD_W], kind);
      assert (data == expected[PAYLOAD_W-1:0])
      else reportMismatch("outData", expected[PAYLOAD_W-1:0], data);
    end
    if (kind == KIND_TAIL)
    begin
      inPacket = 1'b0;
      pktsDone++;
    end
  endtask

  task automatic waitWithReqHigh();
    @(posedge clk);
    #1;
    assert (outReq) else reportProblem("outReq fell before outAck rose");
  endtask

  task automatic waitWithReqLow();
    @(posedge clk);
    #1;
    assert (!outReq) else reportProblem("outReq rose again before outAck fell");
  endtask

  // Four-phase receiver on the output link
  initial
  begin : outputMonitor
    int                   delay;
    flitKind_t            kind;
    logic [PAYLOAD_W-1:0] data;
    forever
    begin
      @(posedge clk);
      #1;
      if (!rst && outReq)
      begin
        kind  = outKind;
        data  = outData;
        delay = int'(takeBits(3));
        repeat (delay) waitWithReqHigh();
        while (holdAck) waitWithReqHigh();
        outAck = 1'b1;
        do
        begin
          @(posedge clk);
          #1;
        end
        while (outReq);
        // Ack stays up a few cycles after req falls so an early new req shows up
        delay = 1 + int'(takeBits(2));
        repeat (delay) waitWithReqLow();
        outAck = 1'b0;
        checkFlit(kind, data);
      end
    end
  end

  always @(negedge clk)
  begin
    for (int k = 0; k < NUM_PORTS; k++)
    begin
      if (inAck[k] && !ackSeen[k])
        ackRises[k]++;
    end
    ackSeen = inAck;
  end

  task automatic runTest(input int first, input int last);
    logic [NUM_PORTS-1:0] used;
    int                   errBefore;
    int                   target;
    errBefore = errors;
    used      = '0;
    for (int i = first; i < last; i++)
      used[casePort[i]] = 1'b1;
    // Packets parked behind a held outAck drain in rotation starting at L
    orderLen = 0;
    orderPos = 0;
    for (int k = 0; k < NUM_PORTS; k++)
    begin
      if (used[k])
      begin
        orderList[orderLen] = k;
        orderLen++;
      end
    end
    holdTest = caseHold[first] != 0;
    holdAck  = holdTest;
    target   = pktsDone + last - first;
    for (int i = first; i < last; i++)
    begin
      automatic int k = i;
      fork
        sendPacket(casePort[k], caseLen[k], caseDelay[k]);
      join_none
    end
    wait fork;
    holdAck = 1'b0;
    wait (pktsDone == target);
    repeat (4) @(posedge clk);
    holdTest = 1'b0;
    if (errors == errBefore)
      testsPassed++;
    else
      testsFailed++;
    $display("test %0d done, %0d packets, %0d errors", caseTest[first], last - first,
             errors - errBefore);
  endtask

  initial
  begin : watchdog
    wait (casesLoaded);
    repeat (limitCycles) @(posedge clk);
    $display("ERROR: run did not finish within %0d cycles", limitCycles);
    $display("TB FAILED");
    $finish;
  end

  initial
  begin : mainSequence
    string line;
    int    fd;
    int    rc;
    int    t;
    int    p;
    int    l;
    int    d;
    int    h;
    int    idx;
    int    first;
    int    totalFlits;
    clk         = 1'b0;
    rst         = 1'b1;
    inReq       = '0;
    outAck      = 1'b0;
    ackSeen     = '0;
    lfsr        = 16'd57840;
    holdTest    = 1'b0;
    holdAck     = 1'b0;
    inPacket    = 1'b0;
    curSrc      = -1;
    pktsDone    = 0;
    errors      = 0;
    testsPassed = 0;
    testsFailed = 0;
    totalFlits  = 0;
    casesLoaded = 1'b0;
    for (int k = 0; k < NUM_PORTS; k++)
    begin
      inKind[k]    = KIND_BODY;
      inData[k]    = '0;
      expWr[k]     = 0;
      expRd[k]     = 0;
      sentFlits[k] = 0;
      ackRises[k]  = 0;
    end
    fd = $fopen(CASES_FILE, "r");
    if (fd == 0)
    begin
      reportProblem($sformatf("cases file %s could not be opened", CASES_FILE));
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        rc   = $fgets(line, fd);
        if (rc > 0 && $sscanf(line, "%d %d %d %d %d", t, p, l, d, h) == 5)
        begin
          caseTest.push_back(t);
          casePort.push_back(p);
          caseLen.push_back(l);
          caseDelay.push_back(d);
          caseHold.push_back(h);
          totalFlits += l;
        end
      end
      $fclose(fd);
    end
    limitCycles = totalFlits * 40 + 200;
    casesLoaded = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;
    assert (outReq == 1'b0) else reportMismatch("outReq", 0, outReq);
    assert (inAck == 5'b0) else reportMismatch("inAck", 0, inAck);
    $display("reset check done, %0d errors", errors);
    idx = 0;
    while (idx < caseTest.size())
    begin
      first = idx;
      while (idx < caseTest.size() && caseTest[idx] == caseTest[first])
        idx++;
      runTest(first, idx);
    end
    // Each request must see exactly one ack rise
    for (int k = 0; k < NUM_PORTS; k++)
    begin
      assert (ackRises[k] == sentFlits[k])
      else reportMismatch($sformatf("inAck[%0d] rise count", k), sentFlits[k], ackRises[k]);
      assert (expRd[k] == expWr[k])
      else reportProblem($sformatf("port %0d has flits that never reached the output", k));
    end
    $display("tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire
